//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Major opcodes, bits 6:2 of a 32-bit instruction
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        LOAD_FP   = 5'b00001,
        MISC_MEM  = 5'b00011,
        OP_IMM    = 5'b00100,
        AUIPC     = 5'b00101,
        OP_IMM_32 = 5'b00110,
        STORE     = 5'b01000,
        STORE_FP  = 5'b01001,
        AMO       = 5'b01011,
        OP        = 5'b01100,
        LUI       = 5'b01101,
        OP_32     = 5'b01110,
        MADD      = 5'b10000,
        MSUB      = 5'b10001,
        NMSUB     = 5'b10010,
        NMADD     = 5'b10011,
        OP_FP     = 5'b10100,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_e;

    typedef logic [31:0] instr_t;
    typedef logic [15:0] half_t;    // Compressed parcel
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef struct packed {
        logic i;
        logic u;
        logic s;
        logic r;
        logic r4;
        logic b;
        logic j;
    } instr_format_t;

endpackage

`default_nettype wire

//--- rtl/fe_pkg.sv
`default_nettype none

package fe_pkg;

    import rv_isa_pkg::*;

    typedef logic [63:0] addr_t;
    typedef logic [63:0] xword_t;
    typedef logic [4:0]  delta_t;    // Bytes consumed from a block
    typedef logic [7:0]  bit_off_t;  // Bit position inside a block

    localparam int SLOTS = 4;

    typedef struct packed {
        logic  valid;
        addr_t pc;
    } pc_req_t;

    typedef struct packed {
        logic   valid;
        delta_t delta;
    } pc_adv_t;

    typedef struct packed {
        logic                 valid;
        addr_t                pc;
        xword_t               data;
        bit_off_t [SLOTS:0]   offset;  // Start of each slot, last one is the end
    } fetch_blk_t;

    typedef struct packed {
        logic   valid;
        addr_t  pc;
        instr_t instr;
        logic   compressed;
    } slot_t;

    typedef struct packed {
        logic      valid;
        addr_t     pc;
        opcode_e   opcode;
        funct3_t   funct3;
        funct7_t   funct7;
        xword_t    imm;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      compressed;
        logic      illegal;
    } decoded_t;

endpackage

`default_nettype wire

//--- rtl/rvc_expand.sv
`default_nettype none

module rvc_expand import rv_isa_pkg::*; (
    input  instr_t parcel,
    output instr_t instr
);
    half_t     c;
    reg_addr_t r_hi;  // rs1'/rd' from bits 9:7
    reg_addr_t r_lo;  // rs2'/rd' from bits 4:2

    assign c    = parcel[15:0];
    assign r_hi = {2'b01, c[9:7]};
    assign r_lo = {2'b01, c[4:2]};

    always_comb begin
        if (parcel[1:0] == 2'b11) begin
            instr = parcel;
        end else begin
            case ({c[15:13], c[1:0]})
                5'b00000:  // C.ADDI4SPN
                    if (c[12:5] == 8'd0)
                        instr = '0;
                    else
                        instr = {2'd0, c[10:7], c[12:11], c[5], c[6], 2'd0,
                                 5'd2, 3'b000, r_lo, OP_IMM, 2'b11};
                5'b01000:  // C.LW
                    instr = {5'd0, c[5], c[12:10], c[6], 2'd0,
                             r_hi, 3'b010, r_lo, LOAD, 2'b11};
                5'b01100:  // C.LD
                    instr = {4'd0, c[6:5], c[12:10], 3'd0,
                             r_hi, 3'b011, r_lo, LOAD, 2'b11};
                5'b11000:  // C.SW
                    instr = {5'd0, c[5], c[12], r_lo, r_hi, 3'b010,
                             c[11:10], c[6], 2'd0, STORE, 2'b11};
                5'b11100:  // C.SD
                    instr = {4'd0, c[6:5], c[12], r_lo, r_hi, 3'b011,
                             c[11:10], 3'd0, STORE, 2'b11};
                5'b00001:  // C.ADDI, C.NOP
                    instr = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], OP_IMM, 2'b11};
                5'b00101:  // C.ADDIW
                    instr = {{7{c[12]}}, c[6:2], c[11:7], 3'b000, c[11:7], OP_IMM_32, 2'b11};
                5'b01001:  // C.LI
                    instr = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, c[11:7], OP_IMM, 2'b11};
                5'b01101:
                    if ({c[12], c[6:2]} == 6'd0)
                        instr = '0;
                    else if (c[11:7] == 5'd2)  // C.ADDI16SP
                        instr = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'd0,
                                 5'd2, 3'b000, 5'd2, OP_IMM, 2'b11};
                    else  // C.LUI
                        instr = {{15{c[12]}}, c[6:2], c[11:7], LUI, 2'b11};
                5'b10001:
                    case (c[11:10])
                        2'b00, 2'b01:  // C.SRLI, C.SRAI
                            instr = {1'b0, c[10], 4'd0, c[12], c[6:2],
                                     r_hi, 3'b101, r_hi, OP_IMM, 2'b11};
                        2'b10:  // C.ANDI
                            instr = {{7{c[12]}}, c[6:2], r_hi, 3'b111, r_hi, OP_IMM, 2'b11};
                        default:
                            case ({c[12], c[6:5]})
                                3'b000:  instr = {7'h20, r_lo, r_hi, 3'b000, r_hi, OP, 2'b11};
                                3'b001:  instr = {7'h00, r_lo, r_hi, 3'b100, r_hi, OP, 2'b11};
                                3'b010:  instr = {7'h00, r_lo, r_hi, 3'b110, r_hi, OP, 2'b11};
                                3'b011:  instr = {7'h00, r_lo, r_hi, 3'b111, r_hi, OP, 2'b11};
                                3'b100:  instr = {7'h20, r_lo, r_hi, 3'b000, r_hi, OP_32, 2'b11};
                                3'b101:  instr = {7'h00, r_lo, r_hi, 3'b000, r_hi, OP_32, 2'b11};
                                default: instr = '0;
                            endcase
                    endcase
                5'b10101:  // C.J
                    instr = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                             c[12], {8{c[12]}}, 5'd0, JAL, 2'b11};
                5'b11001, 5'b11101:  // C.BEQZ, C.BNEZ
                    instr = {{4{c[12]}}, c[6:5], c[2], 5'd0, r_hi, 2'b00, c[13],
                             c[11:10], c[4:3], c[12], BRANCH, 2'b11};
                5'b00010:  // C.SLLI
                    if ({c[12], c[6:2]} == 6'd0)
                        instr = '0;
                    else
                        instr = {6'd0, c[12], c[6:2], c[11:7], 3'b001, c[11:7], OP_IMM, 2'b11};
                5'b01010:  // C.LWSP
                    instr = {4'd0, c[3:2], c[12], c[6:4], 2'd0, 5'd2, 3'b010, c[11:7], LOAD, 2'b11};
                5'b01110:  // C.LDSP
                    instr = {3'd0, c[4:2], c[12], c[6:5], 3'd0, 5'd2, 3'b011, c[11:7], LOAD, 2'b11};
                5'b10010:
                    if (c[6:2] != 5'd0)  // C.MV or C.ADD
                        instr = {7'd0, c[6:2], c[12] ? c[11:7] : 5'd0, 3'b000, c[11:7], OP, 2'b11};
                    else if (c[11:7] != 5'd0)  // C.JR or C.JALR
                        instr = {12'd0, c[11:7], 3'b000, 4'd0, c[12], JALR, 2'b11};
                    else if (c[12])  // C.EBREAK
                        instr = {12'd1, 5'd0, 3'b000, 5'd0, SYSTEM, 2'b11};
                    else
                        instr = '0;
                5'b11010:  // C.SWSP
                    instr = {4'd0, c[8:7], c[12], c[6:2], 5'd2, 3'b010, c[11:9], 2'd0, STORE, 2'b11};
                5'b11110:  // C.SDSP
                    instr = {3'd0, c[9:7], c[12], c[6:2], 5'd2, 3'b011, c[11:10], 3'd0, STORE, 2'b11};
                default:
                    instr = '0;  // Reserved and FP forms
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/fe_pc.sv
`default_nettype none

module fe_pc import fe_pkg::*; #(
    parameter addr_t RST_PC = 64'h400000
) (
    input  logic    clk,
    input  logic    rst,
    output pc_req_t pc_req,
    input  logic    pc_take,
    input  pc_adv_t pc_adv
);
    addr_t pc;
    logic  valid;

    assign pc_req = '{valid: valid, pc: pc};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc    <= RST_PC;
            valid <= 1'b1;
        end else if (pc_take) begin
            if (pc_adv.valid) begin
                pc    <= pc + addr_t'(pc_adv.delta);
                valid <= 1'b1;
            end else begin
                valid <= 1'b0;  // Wait for the outstanding block to report its length
            end
        end
    end

    a_delta_range: assert property (@(posedge clk) disable iff (rst)
        pc_adv.valid |-> pc_adv.delta <= 5'd8);

endmodule

`default_nettype wire

//--- rtl/fe_fetch.sv
`default_nettype none

module fe_fetch import fe_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  pc_req_t    pc_req,
    output logic       pc_take,
    output pc_adv_t    pc_adv,
    output fetch_blk_t blk,
    input  logic       blk_take,
    output logic       icache_req,
    output addr_t      icache_addr,
    input  logic       icache_done,
    input  xword_t     icache_data
);
    logic                sent;
    logic                hold_blk;
    logic                hold_adv;
    addr_t               req_pc;
    xword_t              data_q;
    xword_t              data;
    bit_off_t [SLOTS:0]  off;
    delta_t              delta;

    assign pc_take     = blk_take & ~(sent & ~icache_done) | ~pc_req.valid;
    assign icache_req  = pc_take & pc_req.valid;
    assign icache_addr = pc_req.pc;
    assign data        = icache_done ? icache_data : data_q;

    // Slot k starts where slot k-1 ends
    always_comb begin
        off[0] = '0;
        for (int k = 0; k < SLOTS; k++) begin
            off[k+1] = off[k] + ((data[off[k][5:0] +: 2] == 2'b11) ? 8'd32 : 8'd16);
        end
    end

    // Offsets grow, so the last one inside the block wins
    always_comb begin
        delta = '0;
        for (int k = 1; k <= SLOTS; k++) begin
            if (off[k] <= 8'd64)
                delta = off[k][7:3];
        end
    end

    assign blk    = '{valid: icache_done | hold_blk, pc: req_pc, data: data, offset: off};
    assign pc_adv = '{valid: icache_done | hold_adv, delta: delta};

    always_ff @(posedge clk) begin
        if (rst) begin
            sent     <= 1'b0;
            hold_blk <= 1'b0;
            hold_adv <= 1'b0;
        end else begin
            sent     <= icache_req | (sent & ~icache_done);
            hold_blk <= blk.valid & ~blk_take;
            hold_adv <= pc_adv.valid & ~pc_take;
        end
    end

    always_ff @(posedge clk) begin
        if (icache_req)
            req_pc <= pc_req.pc;
        if (icache_done)
            data_q <= icache_data;
    end

    a_done_outstanding: assert property (@(posedge clk) disable iff (rst)
        icache_done |-> sent);

endmodule

`default_nettype wire

//--- rtl/fe_align.sv
`default_nettype none

module fe_align import rv_isa_pkg::*; import fe_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  fetch_blk_t blk,
    output logic       blk_take,
    output slot_t      slot,
    input  logic       slot_take
);
    addr_t                   base;
    bit_off_t [SLOTS-1:0]    off_q;
    instr_t   [SLOTS-1:0]    win;
    instr_t   [SLOTS-1:0]    exp_w;
    instr_t   [SLOTS-1:0]    instr_q;
    logic     [SLOTS-1:0]    cmp;
    logic     [SLOTS-1:0]    cmp_q;
    logic     [SLOTS-1:0]    mask_n;
    logic     [SLOTS-1:0]    mask_q;
    logic                    load;

    assign blk_take = slot_take & ~mask_q[1] | ~blk.valid;
    assign load     = blk_take & blk.valid;

    always_comb begin
        for (int k = 0; k < SLOTS; k++) begin
            win[k]    = instr_t'({32'd0, blk.data} >> blk.offset[k][5:0]);  // Zero past block end
            cmp[k]    = win[k][1:0] != 2'b11;
            mask_n[k] = blk.offset[k+1] <= 8'd64;  // Slot fits entirely in the block
        end
    end

    for (genvar k = 0; k < SLOTS; k++) begin : g_exp
        rvc_expand u_exp (
            .parcel (win[k]),
            .instr  (exp_w[k])
        );
    end

    assign slot = '{valid: mask_q[0],
                    pc: base + addr_t'(off_q[0][7:3]),
                    instr: instr_q[0],
                    compressed: cmp_q[0]};

    always_ff @(posedge clk) begin
        if (rst)
            mask_q <= '0;
        else if (load)
            mask_q <= mask_n;
        else if (slot_take)
            mask_q <= mask_q >> 1;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            base    <= blk.pc;
            off_q   <= blk.offset[SLOTS-1:0];
            instr_q <= exp_w;
            cmp_q   <= cmp;
        end else if (slot_take) begin
            off_q   <= {bit_off_t'(0), off_q[SLOTS-1:1]};
            instr_q <= {instr_t'(0), instr_q[SLOTS-1:1]};
            cmp_q   <= cmp_q >> 1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fe_decode.sv
`default_nettype none

module fe_decode import rv_isa_pkg::*; import fe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  slot_t    slot,
    output logic     slot_take,
    output decoded_t dec,
    input  logic     dec_ready
);
    instr_t        ir;
    opcode_e       opc;
    instr_format_t fmt;
    xword_t        imm;
    reg_addr_t     rs1;
    reg_addr_t     rs2;
    reg_addr_t     rd;
    logic          ena;

    assign ir        = slot.instr;
    assign opc       = opcode_e'(ir[6:2]);
    assign ena       = dec_ready | ~dec.valid;
    assign slot_take = ena | ~slot.valid;

    always_comb begin
        fmt.i  = opc inside {LOAD, LOAD_FP, MISC_MEM, OP_IMM, OP_IMM_32, JALR, SYSTEM};
        fmt.u  = opc inside {AUIPC, LUI};
        fmt.s  = opc inside {STORE, STORE_FP};
        fmt.r  = opc inside {AMO, OP, OP_32, OP_FP};
        fmt.r4 = opc inside {MADD, MSUB, NMSUB, NMADD};
        fmt.b  = opc == BRANCH;
        fmt.j  = opc == JAL;
    end

    always_comb begin
        imm = '0;
        if (fmt.i)
            imm = {{53{ir[31]}}, ir[30:20]};
        else if (fmt.u)
            imm = {{32{ir[31]}}, ir[31:12], 12'd0};
        else if (fmt.s)
            imm = {{53{ir[31]}}, ir[30:25], ir[11:7]};
        else if (fmt.b)
            imm = {{52{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
        else if (fmt.j)
            imm = {{44{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
    end

    // CSR immediate forms carry uimm in the rs1 field
    assign rs1 = (opc == SYSTEM && ir[14]) ? '0 :
                 (fmt.i | fmt.s | fmt.r | fmt.r4 | fmt.b) ? ir[19:15] : '0;
    assign rs2 = (fmt.r | fmt.s | fmt.b) ? ir[24:20] : '0;
    assign rd  = (fmt.i | fmt.u | fmt.r | fmt.r4 | fmt.j) ? ir[11:7] : '0;

    always_ff @(posedge clk) begin
        if (rst)
            dec.valid <= 1'b0;
        else if (ena)
            dec.valid <= slot.valid;
        if (ena) begin
            dec.pc         <= slot.pc;
            dec.opcode     <= opc;
            dec.funct3     <= ir[14:12];
            dec.funct7     <= ir[31:25];
            dec.imm        <= imm;
            dec.rs1        <= rs1;
            dec.rs2        <= rs2;
            dec.rd         <= rd;
            dec.compressed <= slot.compressed;
            dec.illegal    <= ir[1:0] != 2'b11;
        end
    end

    a_dec_hold: assert property (@(posedge clk) disable iff (rst)
        dec.valid && !dec_ready |=> $stable(dec));

endmodule

`default_nettype wire

//--- rtl/rvfe_top.sv
`default_nettype none

module rvfe_top import fe_pkg::*; #(
    parameter addr_t RST_PC = 64'h400000
) (
    input  logic     clk,
    input  logic     rst,
    output logic     icache_req,
    output addr_t    icache_addr,
    input  logic     icache_done,
    input  xword_t   icache_data,
    output decoded_t dec,
    input  logic     dec_ready
);
    pc_req_t    pc_req;
    logic       pc_take;
    pc_adv_t    pc_adv;
    fetch_blk_t blk;
    logic       blk_take;
    slot_t      slot;
    logic       slot_take;

    fe_pc #(
        .RST_PC (RST_PC)
    ) u_pc (
        .clk     (clk),
        .rst     (rst),
        .pc_req  (pc_req),
        .pc_take (pc_take),
        .pc_adv  (pc_adv)
    );

    fe_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .pc_req      (pc_req),
        .pc_take     (pc_take),
        .pc_adv      (pc_adv),
        .blk         (blk),
        .blk_take    (blk_take),
        .icache_req  (icache_req),
        .icache_addr (icache_addr),
        .icache_done (icache_done),
        .icache_data (icache_data)
    );

    fe_align u_align (
        .clk       (clk),
        .rst       (rst),
        .blk       (blk),
        .blk_take  (blk_take),
        .slot      (slot),
        .slot_take (slot_take)
    );

    fe_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .slot      (slot),
        .slot_take (slot_take),
        .dec       (dec),
        .dec_ready (dec_ready)
    );

endmodule

`default_nettype wire

//--- dv/rvfe_tb.sv
`default_nettype none

module rvfe_tb import rv_isa_pkg::*; import fe_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam addr_t RST_PC      = 64'h400000;
    localparam int    MEM_BYTES   = 2048;
    localparam int    N_WIDE      = 48;    // Leading stretch of 32-bit instructions only
    localparam int    N_INSTR     = 320;
    localparam int    TIMEOUT_CYC = 20000;

    typedef enum logic [3:0] {
        K_ADDI, K_LUI, K_SW, K_BEQ, K_JAL, K_ADD,
        K_CADDI, K_CLI, K_CLW, K_CSW, K_CJ, K_CBEQZ, K_CMV, K_CADD, K_CZERO
    } kind_e;

    // Fields of the base equivalent with unused registers at zero
    typedef struct packed {
        kind_e     kind;
        addr_t     pc;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        xword_t    imm;
    } gen_t;

    logic     clk;
    logic     rst;
    logic     icache_req;
    addr_t    icache_addr;
    logic     icache_done;
    xword_t   icache_data;
    decoded_t dec;
    logic     dec_ready;

    logic [7:0]  mem [MEM_BYTES];
    decoded_t    exp_q [$];
    addr_t       exp_fetch;
    addr_t       req_addr;
    logic        pending;
    int unsigned delay;
    int          dec_errs   = 0;
    int          addr_errs  = 0;
    int          proto_errs = 0;
    int          timeouts   = 0;

    rvfe_top #(
        .RST_PC (RST_PC)
    ) i_dut (
        .clk         (clk),
        .rst         (rst),
        .icache_req  (icache_req),
        .icache_addr (icache_addr),
        .icache_done (icache_done),
        .icache_data (icache_data),
        .dec         (dec),
        .dec_ready   (dec_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic reg_addr_t rand_reg(int lo);
        return reg_addr_t'($urandom_range(31, lo));
    endfunction

    function automatic reg_addr_t rand_creg();
        return reg_addr_t'($urandom_range(15, 8));  // x8 to x15
    endfunction

    function automatic xword_t rand_simm(int w);
        xword_t v;
        xword_t mask;
        v    = {$urandom, $urandom};
        mask = (64'd1 << w) - 64'd1;
        return v[w-1] ? (v | ~mask) : (v & mask);
    endfunction

    // Base RV64I encoding of the generated fields
    function automatic instr_t base_word(gen_t g);
        logic [31:0] m;
        m = g.imm[31:0];
        case (g.kind)
            K_ADDI, K_CADDI, K_CLI:
                return {m[11:0], g.rs1, 3'b000, g.rd, 7'b0010011};
            K_CLW:
                return {m[11:0], g.rs1, 3'b010, g.rd, 7'b0000011};
            K_LUI:
                return {m[31:12], g.rd, 7'b0110111};
            K_SW, K_CSW:
                return {m[11:5], g.rs2, g.rs1, 3'b010, m[4:0], 7'b0100011};
            K_BEQ, K_CBEQZ:
                return {m[12], m[10:5], g.rs2, g.rs1, 3'b000, m[4:1], m[11], 7'b1100011};
            K_JAL, K_CJ:
                return {m[20], m[10:1], m[11], m[19:12], g.rd, 7'b1101111};
            K_ADD, K_CMV, K_CADD:
                return {7'd0, g.rs2, g.rs1, 3'b000, g.rd, 7'b0110011};
            default:
                return '0;
        endcase
    endfunction

    // RVC encoding of the compressed templates
    function automatic half_t rvc_parcel(gen_t g);
        logic [31:0] m;
        m = g.imm[31:0];
        case (g.kind)
            K_CADDI: return {3'b000, m[5], g.rd, m[4:0], 2'b01};
            K_CLI:   return {3'b010, m[5], g.rd, m[4:0], 2'b01};
            K_CLW:   return {3'b010, m[5:3], g.rs1[2:0], m[2], m[6], g.rd[2:0], 2'b00};
            K_CSW:   return {3'b110, m[5:3], g.rs1[2:0], m[2], m[6], g.rs2[2:0], 2'b00};
            K_CJ:    return {3'b101, m[11], m[4], m[9:8], m[10], m[6], m[7], m[3:1], m[5], 2'b01};
            K_CBEQZ: return {3'b110, m[8], m[4:3], g.rs1[2:0], m[7:6], m[2:1], m[5], 2'b01};
            K_CMV:   return {4'b1000, g.rd, g.rs2, 2'b10};
            K_CADD:  return {4'b1001, g.rd, g.rs2, 2'b10};
            default: return '0;
        endcase
    endfunction

    function automatic gen_t make_instr(kind_e k, addr_t pc);
        gen_t g;
        g      = '0;
        g.kind = k;
        g.pc   = pc;
        case (k)
            K_ADDI, K_ADD, K_SW, K_BEQ: begin
                g.rs1 = rand_reg(0);
                if (k == K_ADDI || k == K_ADD)
                    g.rd = rand_reg(0);
                if (k != K_ADDI)
                    g.rs2 = rand_reg(0);
                if (k == K_BEQ)
                    g.imm = rand_simm(13) & ~64'd1;
                else if (k != K_ADD)
                    g.imm = rand_simm(12);
            end
            K_LUI: begin
                g.rd  = rand_reg(0);
                g.imm = rand_simm(32) & ~64'hfff;
            end
            K_JAL: begin
                g.rd  = rand_reg(0);
                g.imm = rand_simm(21) & ~64'd1;
            end
            K_CADDI, K_CLI: begin
                g.rd  = rand_reg(1);
                g.rs1 = (k == K_CADDI) ? g.rd : 5'd0;
                g.imm = rand_simm(6);
            end
            K_CLW, K_CSW: begin
                g.rs1 = rand_creg();
                if (k == K_CLW)
                    g.rd = rand_creg();
                else
                    g.rs2 = rand_creg();
                g.imm = xword_t'($urandom_range(31, 0)) << 2;  // Zero-extended word offset
            end
            K_CJ:
                g.imm = rand_simm(12) & ~64'd1;
            K_CBEQZ: begin
                g.rs1 = rand_creg();
                g.imm = rand_simm(9) & ~64'd1;
            end
            K_CMV, K_CADD: begin
                g.rd  = rand_reg(1);
                g.rs1 = (k == K_CADD) ? g.rd : 5'd0;
                g.rs2 = rand_reg(1);
            end
            default: ;
        endcase
        return g;
    endfunction

    function automatic decoded_t ref_decode(gen_t g);
        decoded_t d;
        instr_t   w;
        d            = '0;
        d.valid      = 1'b1;
        d.pc         = g.pc;
        d.compressed = g.kind >= K_CADDI;
        if (g.kind == K_CZERO) begin
            d.illegal = 1'b1;
        end else begin
            w        = base_word(g);
            d.opcode = opcode_e'(w[6:2]);
            d.funct3 = w[14:12];  // Raw bits in every format
            d.funct7 = w[31:25];
            d.imm    = g.imm;
            d.rs1    = g.rs1;
            d.rs2    = g.rs2;
            d.rd     = g.rd;
        end
        return d;
    endfunction

    function automatic logic [7:0] byte_at(addr_t a);
        addr_t rel;
        rel = a - RST_PC;
        if (a >= RST_PC && rel < addr_t'(MEM_BYTES))
            return mem[int'(rel)];
        return 8'h00;  // Zero parcels past the program
    endfunction

    function automatic xword_t read_block(addr_t a);
        xword_t d;
        for (int b = 0; b < 8; b++)
            d[8*b +: 8] = byte_at(a + addr_t'(b));
        return d;
    endfunction

    // First instruction of the block at a that does not end inside it
    function automatic addr_t next_fetch_addr(addr_t a);
        addr_t      p;
        addr_t      len;
        logic [7:0] lo;
        p = a;
        for (int k = 0; k < SLOTS; k++) begin
            lo  = byte_at(p);
            len = (lo[1:0] == 2'b11) ? 64'd4 : 64'd2;
            if (p + len > a + 64'd8)
                break;
            p = p + len;
        end
        return p;
    endfunction

    task automatic load_program();
        addr_t  pc;
        gen_t   g;
        kind_e  k;
        instr_t w;
        int     len;
        foreach (mem[i])
            mem[i] = 8'h00;
        pc = RST_PC;
        for (int n = 0; n < N_INSTR; n++) begin
            if (n < N_WIDE)
                k = kind_e'($urandom_range(5, 0));
            else
                k = kind_e'($urandom_range(14, 0));
            g = make_instr(k, pc);
            if (k >= K_CADDI) begin
                w   = {16'd0, rvc_parcel(g)};
                len = 2;
            end else begin
                w   = base_word(g);
                len = 4;
            end
            for (int b = 0; b < len; b++)
                mem[int'(pc - RST_PC) + b] = w[8*b +: 8];
            pc = pc + addr_t'(len);
            exp_q.push_back(ref_decode(g));
        end
    endtask

    task automatic check_decoded(decoded_t got, decoded_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: decoded record at pc %h differs, got %h expected %h",
                     $time, exp.pc, got, exp);
            dec_errs++;
        end
    endtask

    task automatic check_addr(addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: fetch address got %h expected %h", $time, got, exp);
            addr_errs++;
        end
    endtask

    // Instruction cache with a random answer delay
    always @(posedge clk) begin
        if (rst) begin
            icache_done <= 1'b0;
            pending     = 1'b0;
            exp_fetch   = RST_PC;
        end else begin
            icache_done <= 1'b0;
            if (icache_req) begin
                if (pending) begin
                    $display("second fetch request issued while one is still outstanding");
                    proto_errs++;
                end
                check_addr(icache_addr, exp_fetch);
                exp_fetch = next_fetch_addr(exp_fetch);
                req_addr  = icache_addr;
                delay     = $urandom_range(3, 0);
                pending   = 1'b1;
            end
            if (pending) begin
                if (delay == 0) begin
                    icache_done <= 1'b1;
                    icache_data <= read_block(req_addr);
                    pending     = 1'b0;
                end else begin
                    delay--;
                end
            end
        end
    end

    always @(posedge clk) begin
        dec_ready <= ($urandom_range(3, 0) != 0);
    end

    always @(posedge clk) begin
        if (!rst && dec.valid && dec_ready && exp_q.size() > 0)
            check_decoded(dec, exp_q.pop_front());
    end

    initial begin
        int cycles;
        void'($urandom(32'hed49));
        rst         = 1'b1;
        icache_done = 1'b0;
        icache_data = '0;
        dec_ready   = 1'b0;
        load_program();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        if (dec.valid !== 1'b0) begin
            $display("decoded output is valid right after reset");
            proto_errs++;
        end
        cycles = 0;
        while (exp_q.size() != 0 && cycles < TIMEOUT_CYC) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d decoded instructions not received", exp_q.size());
            timeouts++;
        end
        $display("errors: decode %0d, fetch address %0d, protocol %0d, timeout %0d",
                 dec_errs, addr_errs, proto_errs, timeouts);
        if (dec_errs + addr_errs + proto_errs + timeouts == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- rvfe.f
rtl/rv_isa_pkg.sv
rtl/fe_pkg.sv
rtl/rvc_expand.sv
rtl/fe_pc.sv
rtl/fe_fetch.sv
rtl/fe_align.sv
rtl/fe_decode.sv
rtl/rvfe_top.sv
dv/rvfe_tb.sv

//--- Bender.yml
package:
  name: rvfe

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/fe_pkg.sv
  - rtl/rvc_expand.sv
  - rtl/fe_pc.sv
  - rtl/fe_fetch.sv
  - rtl/fe_align.sv
  - rtl/fe_decode.sv
  - rtl/rvfe_top.sv
  - target: simulation
    files:
      - dv/rvfe_tb.sv
